// ==== source/dds_pkg.sv ====
/*
  dds package: widths, register map, dither LFSR constants and the
  bus and sample types shared by the DDS stream blocks
*/
package dds_pkg;

  // phase datapath
  localparam int PHASE_BITS = 32;
  localparam int QUANT_BITS = 20;
  localparam int LUT_ADDR_BITS = PHASE_BITS - QUANT_BITS;
  localparam int LUT_DEPTH = 2 ** LUT_ADDR_BITS;
  localparam real PI = 3.14159265358979;

  // sample words, lane 0 is earliest in time
  localparam int SAMPLE_WIDTH = 16;
  localparam int PARALLEL_SAMPLES = 4;
  localparam int LANE_BITS = $clog2(PARALLEL_SAMPLES);
  // advances from cycle phase to output word
  localparam int CORE_LATENCY = 5;

  // buffering between core and serializer
  localparam int FIFO_DEPTH = 16;
  localparam int LEVEL_BITS = 8;

  // galois LFSR, shifts right, taps applied when a 1 falls out
  localparam int LFSR_WIDTH = 16;
  localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 16'hACE1;
  localparam logic [LFSR_WIDTH-1:0] LFSR_TAPS = 16'hB400;

  // apb register map
  localparam int APB_ADDR_BITS = 12;
  localparam logic [APB_ADDR_BITS-1:0] ADDR_PHASE_INC = 12'h000;
  localparam logic [APB_ADDR_BITS-1:0] ADDR_CTRL = 12'h004;
  localparam logic [APB_ADDR_BITS-1:0] ADDR_STATUS = 12'h008;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef sample_t [PARALLEL_SAMPLES-1:0] sample_word_t;
  typedef logic [PARALLEL_SAMPLES-1:0][LFSR_WIDTH-1:0] lfsr_lanes_t;

  // enable sits in bit 0
  typedef struct packed {
    logic [29:0] reserved;
    logic        clear_underrun;
    logic        enable;
  } ctrl_t;

  // one write word, viewed by address
  typedef union packed {
    logic [PHASE_BITS-1:0] phase_inc;
    ctrl_t                 ctrl;
  } apb_wdata_u;

  typedef struct packed {
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [APB_ADDR_BITS-1:0] paddr;
    apb_wdata_u               pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [22:0]           reserved;
    logic [LEVEL_BITS-1:0] fifo_level;
    logic                  underrun;
  } status_t;

endpackage

// ==== source/dds_apb_regs.sv ====
/*
  dds register block: APB slave holding the phase increment, the
  enable bit and a clear pulse, with status readback
*/
module dds_apb_regs (
  input  logic                            clk,
  input  logic                            reset,
  input  dds_pkg::apb_req_t               apb_req,
  output dds_pkg::apb_rsp_t               apb_rsp,
  output logic [dds_pkg::PHASE_BITS-1:0]  phase_inc,
  output logic                            enable,
  output logic                            clear_underrun,
  input  logic                            underrun,
  input  logic [dds_pkg::LEVEL_BITS-1:0]  fifo_level
);
  import dds_pkg::*;

  logic       access;
  logic       wr_en;
  apb_wdata_u wdata;
  ctrl_t      ctrl_rd;
  status_t    status_rd;
  logic [31:0] rdata;

  // access phase, always completes in one cycle
  assign access = apb_req.psel && apb_req.penable;
  assign wr_en = access && apb_req.pwrite;
  assign wdata = apb_req.pwdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase_inc <= '0;
      enable <= 1'b0;
      clear_underrun <= 1'b0;
    end else begin
      // pulse lasts a single cycle
      clear_underrun <= 1'b0;
      if (wr_en) begin
        // address picks the view of the write word
        case (apb_req.paddr)
          ADDR_PHASE_INC: begin
            phase_inc <= wdata.phase_inc;
          end
          ADDR_CTRL: begin
            enable <= wdata.ctrl.enable;
            clear_underrun <= wdata.ctrl.clear_underrun;
          end
          default: begin
            // status is read only, other addresses ignore writes
          end
        endcase
      end
    end
  end

  // readback words
  always_comb begin
    ctrl_rd = '0;
    ctrl_rd.enable = enable;
    status_rd = '0;
    status_rd.underrun = underrun;
    status_rd.fifo_level = fifo_level;
    case (apb_req.paddr)
      ADDR_PHASE_INC: rdata = phase_inc;
      ADDR_CTRL:      rdata = ctrl_rd;
      ADDR_STATUS:    rdata = status_rd;
      default:        rdata = '0;
    endcase
  end

  // every address decodes, so no error response
  always_comb begin
    apb_rsp.prdata = rdata;
    apb_rsp.pready = access;
    apb_rsp.pslverr = 1'b0;
  end

endmodule

// ==== source/lfsr16_parallel.sv ====
/*
  parallel dither LFSR: 16-bit galois LFSR stepping one lane count
  per enable and showing each intermediate state in lane order
*/
module lfsr16_parallel (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enable,
  input  logic                 restart,
  output dds_pkg::lfsr_lanes_t state_out
);
  import dds_pkg::*;

  logic [LFSR_WIDTH-1:0] state;
  lfsr_lanes_t           steps;

  // one right shift, taps xored in when the lsb falls out
  function automatic logic [LFSR_WIDTH-1:0] galois_step(input logic [LFSR_WIDTH-1:0] s);
    galois_step = (s >> 1) ^ (s[0] ? LFSR_TAPS : '0);
  endfunction

  // unrolled chain, lane i is i+1 steps past state
  always_comb begin
    steps[0] = galois_step(state);
    for (int i = 1; i < PARALLEL_SAMPLES; i++) begin
      steps[i] = galois_step(steps[i-1]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset || restart) begin
      state <= LFSR_SEED;
      state_out <= '0;
    end else if (enable) begin
      // last lane becomes the base for the next word
      state <= steps[PARALLEL_SAMPLES-1];
      state_out <= steps;
    end
  end

endmodule

// ==== source/dds_core.sv ====
/*
  dds core: phase accumulator with LFSR phase dither and a cosine
  lookup, producing one word of parallel samples per advance
*/
module dds_core (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           enable,
  input  logic [dds_pkg::PHASE_BITS-1:0] phase_inc,
  output logic                           word_valid,
  output dds_pkg::sample_word_t          word,
  input  logic                           word_ready
);
  import dds_pkg::*;

  typedef logic [PARALLEL_SAMPLES-1:0][PHASE_BITS-1:0] lane_phase_t;

  logic                                        advance;
  logic [CORE_LATENCY-1:0]                     valid_sr;
  logic [PHASE_BITS-1:0]                       cycle_phase;
  lane_phase_t                                 inc_mult;
  lane_phase_t                                 sample_phase;
  lane_phase_t                                 phase_dithered;
  logic [PARALLEL_SAMPLES-1:0][LUT_ADDR_BITS-1:0] phase_quant;
  sample_word_t                                lut_data;
  lfsr_lanes_t                                 dither;
  sample_t                                     lut [LUT_DEPTH];

  // full period cosine table, indexed by the top phase bits
  initial begin
    for (int i = 0; i < LUT_DEPTH; i++) begin
      lut[i] = sample_t'(int'($floor($cos(2.0 * PI * i / LUT_DEPTH)
                                      * (2.0 ** (SAMPLE_WIDTH - 1) - 0.5) - 0.5)));
    end
  end

  // move when downstream takes the word or the output slot is empty
  assign advance = enable && (word_ready || !word_valid);
  assign word_valid = valid_sr[CORE_LATENCY-1];

  // lane multiples of the increment
  // top entry steps the cycle phase by a whole word
  always_ff @(posedge clk) begin
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      inc_mult[i] <= phase_inc * PHASE_BITS'(i + 1);
    end
  end

  // accumulator and fill marker, both restart while disabled
  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      cycle_phase <= '0;
      valid_sr <= '0;
    end else if (advance) begin
      cycle_phase <= cycle_phase + inc_mult[PARALLEL_SAMPLES-1];
      valid_sr <= {valid_sr[CORE_LATENCY-2:0], 1'b1};
    end
  end

  // dither states line up with sample_phase one advance later
  lfsr16_parallel dither_lfsr (
    .clk       (clk),
    .reset     (reset),
    .enable    (advance),
    .restart   (!enable),
    .state_out (dither)
  );

  // five register stages, all frozen together under back-pressure
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
        // stage 1: lane phase from the shared cycle phase
        if (i == 0) begin
          sample_phase[i] <= cycle_phase;
        end else begin
          sample_phase[i] <= cycle_phase + inc_mult[i-1];
        end
        // stage 2: dither lands just under the quantization cut
        phase_dithered[i] <= sample_phase[i]
                             + PHASE_BITS'({dither[i], {(QUANT_BITS - LFSR_WIDTH){1'b0}}});
        // stage 3: drop the low phase bits
        phase_quant[i] <= phase_dithered[i][PHASE_BITS-1:QUANT_BITS];
        // stage 4: table read
        lut_data[i] <= lut[phase_quant[i]];
      end
      // stage 5: output register after the table
      word <= lut_data;
    end
  end

endmodule

// ==== source/sample_fifo.sv ====
/*
  sample FIFO: synchronous circular buffer of sample words with
  same-cycle push and pop, a flush and a fill level
*/
module sample_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           flush,
  input  logic                           in_valid,
  input  dds_pkg::sample_word_t          in_word,
  output logic                           in_ready,
  output logic                           out_valid,
  output dds_pkg::sample_word_t          out_word,
  input  logic                           out_ready,
  output logic [dds_pkg::LEVEL_BITS-1:0] level
);
  import dds_pkg::*;

  sample_word_t            mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [LEVEL_BITS-1:0]   count;
  logic                    push;
  logic                    pop;

  assign in_ready = count != LEVEL_BITS'(DEPTH);
  assign out_valid = count != '0;
  // head word is visible the cycle after it is written
  assign out_word = mem[rd_ptr];
  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;
  assign level = count;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_word;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      // pointers wrap at DEPTH, which need not be a power of two
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== source/sample_serializer.sv ====
/*
  sample serializer: unpacks sample words one lane per accepted
  sample and flags a sticky underrun when the stream runs dry
*/
module sample_serializer (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  enable,
  input  logic                                  clear_underrun,
  input  logic                                  word_valid,
  input  dds_pkg::sample_word_t                 word,
  output logic                                  word_ready,
  output logic                                  sample_valid,
  output logic signed [dds_pkg::SAMPLE_WIDTH-1:0] sample,
  input  logic                                  sample_ready,
  output logic                                  underrun
);
  import dds_pkg::*;

  sample_word_t         hold;
  logic [LANE_BITS-1:0] lane;
  logic                 last_lane;
  logic                 take_sample;
  logic                 take_word;
  logic                 delivered;

  assign last_lane = lane == LANE_BITS'(PARALLEL_SAMPLES - 1);
  assign take_sample = sample_valid && sample_ready;
  // next word is requested as the last lane leaves, so no bubble
  assign word_ready = enable && (!sample_valid || (take_sample && last_lane));
  assign take_word = word_valid && word_ready;
  assign sample = hold[lane];

  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      sample_valid <= 1'b0;
      lane <= '0;
      delivered <= 1'b0;
    end else if (take_word) begin
      sample_valid <= 1'b1;
      lane <= '0;
      delivered <= 1'b1;
    end else if (take_sample) begin
      if (last_lane) begin
        sample_valid <= 1'b0;
      end else begin
        lane <= lane + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_word) begin
      hold <= word;
    end
  end

  // sink wants data we do not have, after the stream has started
  // a fresh underrun wins over a clear in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      underrun <= 1'b0;
    end else if (enable && sample_ready && !sample_valid && delivered) begin
      underrun <= 1'b1;
    end else if (clear_underrun) begin
      underrun <= 1'b0;
    end
  end

endmodule

// ==== source/dds_top.sv ====
/*
  dds top: APB register block, DDS core, sample FIFO and serializer
  joined into one streaming cosine source
*/
module dds_top (
  input  logic                                  clk,
  input  logic                                  reset,
  input  dds_pkg::apb_req_t                     apb_req,
  output dds_pkg::apb_rsp_t                     apb_rsp,
  output logic                                  sample_valid,
  output logic signed [dds_pkg::SAMPLE_WIDTH-1:0] sample,
  input  logic                                  sample_ready
);
  import dds_pkg::*;

  logic [PHASE_BITS-1:0] phase_inc;
  logic                  enable;
  logic                  clear_underrun;
  logic                  underrun;
  logic [LEVEL_BITS-1:0] fifo_level;
  // core to FIFO
  logic                  word_valid;
  sample_word_t          word;
  logic                  word_ready;
  // FIFO to serializer
  logic                  fifo_valid;
  sample_word_t          fifo_word;
  logic                  fifo_ready;

  dds_apb_regs regs (
    .clk(clk), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .phase_inc(phase_inc), .enable(enable), .clear_underrun(clear_underrun),
    .underrun(underrun), .fifo_level(fifo_level)
  );

  dds_core core (
    .clk(clk), .reset(reset), .enable(enable), .phase_inc(phase_inc),
    .word_valid(word_valid), .word(word), .word_ready(word_ready)
  );

  // disabling flushes any buffered words
  sample_fifo #(.DEPTH(FIFO_DEPTH)) fifo (
    .clk(clk), .reset(reset), .flush(!enable),
    .in_valid(word_valid), .in_word(word), .in_ready(word_ready),
    .out_valid(fifo_valid), .out_word(fifo_word), .out_ready(fifo_ready),
    .level(fifo_level)
  );

  sample_serializer serializer (
    .clk(clk), .reset(reset), .enable(enable), .clear_underrun(clear_underrun),
    .word_valid(fifo_valid), .word(fifo_word), .word_ready(fifo_ready),
    .sample_valid(sample_valid), .sample(sample), .sample_ready(sample_ready),
    .underrun(underrun)
  );

endmodule

// ==== verification/dds_tb.sv ====
/*
  dds testbench driving the APB register block and the sample stream
  and checking every accepted sample against a reference cosine rule
*/
module dds_tb;
  import dds_pkg::*;

  localparam int APB_TIMEOUT = 10;
  localparam int VALID_TIMEOUT = 40;
  localparam int READY_HIGH = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_LOW = 2;

  logic                           clk;
  logic                           reset;
  apb_req_t                       apb_req;
  apb_rsp_t                       apb_rsp;
  logic                           sample_valid;
  logic signed [SAMPLE_WIDTH-1:0] sample;
  logic                           sample_ready;

  // reference state shared with the checking process
  logic [PHASE_BITS-1:0]          ref_inc;
  logic signed [SAMPLE_WIDTH-1:0] expected_sample;
  int                             sample_count;
  int                             total_checked;
  int                             error_count;
  int                             test_start_errors;
  int                             tests_passed;
  int                             tests_failed;
  int                             ready_mode;
  logic [31:0]                    rd_word;
  logic [31:0]                    wr_word;
  status_t                        status;

  dds_top DUT (
    .clk(clk), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .sample_valid(sample_valid), .sample(sample), .sample_ready(sample_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // expected serial sample k from the dithered phase and the cosine table
  function automatic logic signed [SAMPLE_WIDTH-1:0] ref_sample(input int k,
                                                                input logic [31:0] inc);
    logic [15:0] lfsr;
    logic [31:0] phase;
    int          idx;
    int          s;
    real         angle;
    real         value;
    lfsr = LFSR_SEED;
    // state after k+1 galois steps
    for (s = 0; s <= k; s++) begin
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 16'h0000);
    end
    phase = inc * 32'(k) + {12'h000, lfsr, 4'h0};
    idx = int'(phase[31:20]);
    angle = 2.0 * 3.141592653589793 * real'(idx) / 4096.0;
    value = $floor($cos(angle) * 32767.5 - 0.5);
    ref_sample = 16'(int'(value));
  endfunction

  // sink ready driven just after each rising edge
  initial begin
    sample_ready = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      case (ready_mode)
        READY_RANDOM: sample_ready = ($urandom & 32'h1) != 0;
        READY_LOW:    sample_ready = 1'b0;
        default:      sample_ready = 1'b1;
      endcase
    end
  end

  // values hold from here until the rising edge that completes the transfer
  always @(negedge clk) begin
    if (!reset && sample_valid && sample_ready) begin
      expected_sample = ref_sample(sample_count, ref_inc);
      assert (sample == expected_sample) else begin
        $display("Mismatch sample[%0d]: got %h expected %h", sample_count, sample,
                 expected_sample);
        error_count++;
      end
      sample_count++;
      total_checked++;
    end
  end

  // two cycle APB transfer entered and left just after a rising edge
  task automatic apb_access(input logic write, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = write;
    apb_req.paddr = addr;
    apb_req.pwdata.phase_inc = wdata;
    // no ready in the setup phase
    @(negedge clk);
    assert (!apb_rsp.pready) else begin
      $display("Mismatch pready in setup phase: got %h expected %h", apb_rsp.pready, 1'b0);
      error_count++;
    end
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!apb_rsp.pready && waited < APB_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    rdata = apb_rsp.prdata;
    if (!apb_rsp.pready) begin
      $display("APB access to address %h got no pready within %0d cycles", addr, APB_TIMEOUT);
      error_count++;
    end
    assert (!apb_rsp.pslverr) else begin
      $display("Mismatch pslverr: got %h expected %h", apb_rsp.pslverr, 1'b0);
      error_count++;
    end
    @(posedge clk);
    #2;
    apb_req = '0;
  endtask

  task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_read(input logic [11:0] addr, output logic [31:0] data);
    apb_access(1'b0, addr, 32'h0, data);
  endtask

  task automatic write_ctrl(input logic en, input logic clr);
    ctrl_t c;
    c = '0;
    c.enable = en;
    c.clear_underrun = clr;
    reg_write(ADDR_CTRL, c);
  endtask

  task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic wait_first_valid();
    int waited;
    waited = 0;
    while (!sample_valid && waited < VALID_TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!sample_valid) begin
      $display("no sample_valid within %0d cycles after enable", VALID_TIMEOUT);
      error_count++;
    end
  endtask

  task automatic wait_samples(input int count, input int max_cycles);
    int target;
    int waited;
    target = sample_count + count;
    waited = 0;
    while (sample_count < target && waited < max_cycles) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (sample_count < target) begin
      $display("timed out after %0d cycles with %0d of %0d samples", max_cycles,
               count - (target - sample_count), count);
      error_count++;
    end
  endtask

  // stragglers after disable are still checked against the old index
  task automatic wait_stream_idle();
    int waited;
    waited = 0;
    while (sample_valid && waited < VALID_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (sample_valid) begin
      $display("sample_valid still set %0d cycles after disable", VALID_TIMEOUT);
      error_count++;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic begin_test();
    test_start_errors = error_count;
  endtask

  task automatic end_test(input string name);
    if (error_count == test_start_errors) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, error_count - test_start_errors);
    end
  endtask

  initial begin
    void'($urandom(51));
    reset = 1'b1;
    apb_req = '0;
    ready_mode = READY_HIGH;
    ref_inc = '0;
    sample_count = 0;
    total_checked = 0;
    error_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    @(posedge clk);
    #2;

    // registers come up cleared and the phase increment reads back
    begin_test();
    reg_read(ADDR_PHASE_INC, rd_word);
    check_reg("PHASE_INC", rd_word, 32'h0);
    reg_read(ADDR_CTRL, rd_word);
    check_reg("CTRL", rd_word, 32'h0);
    wr_word = $urandom;
    reg_write(ADDR_PHASE_INC, wr_word);
    reg_read(ADDR_PHASE_INC, rd_word);
    check_reg("PHASE_INC", rd_word, wr_word);
    reg_read(ADDR_STATUS, rd_word);
    check_reg("STATUS", rd_word, 32'h0);
    end_test("register_access");

    // steady stream from phase zero
    begin_test();
    ref_inc = 32'h0100_0000;
    reg_write(ADDR_PHASE_INC, ref_inc);
    sample_count = 0;
    write_ctrl(1'b1, 1'b0);
    wait_first_valid();
    wait_samples(200, 400);
    end_test("continuous_stream");

    // random sink stalls while the index keeps counting
    begin_test();
    ready_mode = READY_RANDOM;
    wait_samples(300, 2000);
    end_test("back_pressure");

    // restart with a fresh increment
    begin_test();
    ready_mode = READY_HIGH;
    write_ctrl(1'b0, 1'b0);
    wait_stream_idle();
    ref_inc = $urandom;
    reg_write(ADDR_PHASE_INC, ref_inc);
    sample_count = 0;
    write_ctrl(1'b1, 1'b0);
    wait_first_valid();
    wait_samples(200, 400);
    end_test("restart");

    // sticky flag clears and a stalled sink fills the FIFO
    begin_test();
    write_ctrl(1'b1, 1'b1);
    wait_samples(100, 200);
    reg_read(ADDR_STATUS, rd_word);
    status = rd_word;
    check_reg("STATUS.underrun", 32'(status.underrun), 32'h0);
    ready_mode = READY_LOW;
    repeat (20) @(posedge clk);
    #2;
    reg_read(ADDR_STATUS, rd_word);
    status = rd_word;
    // a stalled sink leaves every FIFO slot occupied
    check_reg("STATUS.fifo_level", 32'(status.fifo_level), 32'(FIFO_DEPTH));
    end_test("underrun_flag");

    $display("tests passed %0d failed %0d, samples checked %0d, errors %0d",
             tests_passed, tests_failed, total_checked, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
source/dds_pkg.sv
source/dds_apb_regs.sv
source/lfsr16_parallel.sv
source/dds_core.sv
source/sample_fifo.sv
source/sample_serializer.sv
source/dds_top.sv
verification/dds_tb.sv

// ==== Makefile ====
# Verilator build and run of the DDS testbench

VERILATOR ?= verilator
TOP       ?= dds_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/$(TOP)_sim

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)_sim
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "^TEST OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
